//--- build.f
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/reg_file.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/rv_core.sv
bench/rv_core_tb.sv

//--- bench/rv_core_tb.sv
// testbench for the rv32 pipeline core
// models the instruction rom, runs a directed program and checks every
// register write against an ordered list of expected writes
module rv_core_tb import rv_pkg::*; ();

    localparam logic [XLEN-1:0] RESET_PC   = '0;
    localparam int              DMEM_WORDS = 256;
    localparam int              ROM_WORDS  = 64;
    localparam int              PROG_LEN   = 32;
    localparam int              TIMEOUT_CYCLES = 2 * PROG_LEN + 20;
    localparam logic [31:0]     SEED = 32'h4799;

    logic            clk;
    logic            rst_n;
    logic [XLEN-1:0] imem_addr;
    instr_u          imem_data;
    wb_t             wb;
    logic            ohalt;

    logic [31:0] rom [0:ROM_WORDS-1];
    logic [4:0]  exp_rd   [0:63];  // expected writes, in retirement order
    logic [31:0] exp_data [0:63];
    int          exp_tag  [0:63];  // test number of each write
    int          n_exp;
    int          head;             // next expected write
    int          reported;         // writes already walked for test lines
    int          test_fail [1:6];
    string       test_name [1:6];
    int          fail_count;
    int          tests_passed;
    int          tests_failed;
    int          cycles;
    logic        halted;

    rv_core #(
        .RESET_PC   (RESET_PC),
        .DMEM_WORDS (DMEM_WORDS)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb        (wb),
        .ohalt     (ohalt)
    );

    always #5 clk = ~clk;

    // ==================================================================
    // instruction encoders, straight from the rv32i formats
    // ==================================================================
    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq(input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [XLEN-1:0] addr);
        if (addr[XLEN-1:2] < ROM_WORDS) return rom[addr[XLEN-1:2]];
        return NOP_INSTR; // past the rom, or pc still unknown
    endfunction

    task automatic expect_write(input int tag, input logic [4:0] rd, input logic [31:0] data);
        exp_tag[n_exp]  = tag;
        exp_rd[n_exp]   = rd;
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    task automatic flag_error(input int tag);
        test_fail[tag]++;
        fail_count++;
    endtask

    task automatic write_mismatch(input logic [4:0] rd, input logic [31:0] data, input int idx);
        if (idx >= n_exp) begin
            $display("[FAIL] t=%0t unexpected write x%0d=%h", $time, rd, data);
            flag_error(6);
        end else begin
            $display("[FAIL] t=%0t write x%0d=%h, expected x%0d=%h",
                     $time, rd, data, exp_rd[idx], exp_data[idx]);
            flag_error(exp_tag[idx]);
        end
    endtask

    task automatic report_test(input int tag);
        if (test_fail[tag] == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", tag, test_name[tag]);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d check(s) failed", tag, test_name[tag], test_fail[tag]);
        end
    endtask

    // ==================================================================
    // directed program and its expected writes
    // ==================================================================
    task automatic build_program();
        logic [11:0] ia;
        logic [11:0] ib;
        logic [31:0] x [1:8];
        ia = 12'($urandom);
        ib = 12'($urandom);
        for (int i = 0; i < ROM_WORDS; i++) rom[i] = NOP_INSTR;
        // dependent alu chain
        x[1] = {{20{ia[11]}}, ia};
        x[2] = x[1] + {{20{ib[11]}}, ib};
        x[3] = x[2] + x[1];
        x[4] = x[3] - x[1];
        x[5] = x[4] & x[2];
        x[6] = x[5] | x[3];
        x[7] = ($signed(x[6]) < $signed(x[1])) ? 32'd1 : 32'd0;
        x[8] = (x[7] < x[1]) ? 32'd1 : 32'd0; // unsigned compare
        rom[0] = addi(1, 0, ia);
        rom[1] = addi(2, 1, ib);
        rom[2] = rtype(7'h00, 1, 2, 3'b000, 3);
        rom[3] = rtype(7'h20, 1, 3, 3'b000, 4);
        rom[4] = rtype(7'h00, 2, 4, 3'b111, 5);
        rom[5] = rtype(7'h00, 3, 5, 3'b110, 6);
        rom[6] = rtype(7'h00, 1, 6, 3'b010, 7);
        rom[7] = rtype(7'h00, 1, 7, 3'b011, 8);
        for (int r = 1; r <= 8; r++) expect_write(2, 5'(r), x[r]);
        // store, load straight after, then use the loaded value
        rom[8]  = addi(9, 0, 12'd64);
        rom[9]  = store_word(6, 9, 12'd0);
        rom[10] = load_word(10, 9, 12'd0);
        rom[11] = rtype(7'h00, 2, 10, 3'b000, 11);
        expect_write(3, 9, 32'd64);
        expect_write(3, 10, x[6]);
        expect_write(3, 11, x[6] + x[2]);
        // beq not taken at pc 52, taken at pc 60 to pc 76
        rom[12] = addi(12, 0, 12'd5);
        rom[13] = beq(12, 0, 13'd8);
        rom[14] = addi(13, 12, 12'd1);
        rom[15] = beq(13, 13, 13'd16);
        rom[16] = addi(31, 0, 12'd1); // shadow slots
        rom[17] = addi(31, 0, 12'd2);
        rom[18] = addi(31, 0, 12'd3);
        rom[19] = addi(14, 13, 12'd1);
        expect_write(4, 12, 32'd5);
        expect_write(4, 13, 32'd6);
        expect_write(4, 14, 32'd7);
        // jal at pc 80 to pc 96, jalr at pc 100 to pc 116
        rom[20] = jal(15, 21'd16);
        rom[21] = addi(31, 0, 12'd4);
        rom[22] = addi(31, 0, 12'd5);
        rom[23] = addi(31, 0, 12'd6);
        rom[24] = addi(16, 0, 12'd116);
        rom[25] = jalr(17, 16, 12'd0);
        rom[26] = addi(31, 0, 12'd7);
        rom[27] = addi(31, 0, 12'd8);
        rom[28] = addi(31, 0, 12'd9);
        rom[29] = addi(18, 17, 12'd1);
        expect_write(5, 15, 32'd84);
        expect_write(5, 16, 32'd116);
        expect_write(5, 17, 32'd104);
        expect_write(5, 18, 32'd105);
        rom[30] = 32'h0000_0073; // ecall
        rom[31] = NOP_INSTR;
    endtask

    // ==================================================================
    // checks
    // ==================================================================
    a_start_pc: assert property (@(posedge clk) $rose(rst_n) |-> imem_addr == RESET_PC)
        else begin
            $display("[FAIL] t=%0t first fetch address %h", $time, $sampled(imem_addr));
            flag_error(1);
        end

    a_quiet_start: assert property (@(posedge clk)
        $rose(rst_n) |-> (!wb.reg_wr && !ohalt) [*4])
        else begin
            $display("[FAIL] t=%0t write or halt before the pipeline filled", $time);
            flag_error(1);
        end

    a_write_matches: assert property (@(posedge clk) disable iff (!rst_n)
        wb.reg_wr |-> (head < n_exp && wb.rd == exp_rd[head] && wb.data == exp_data[head]))
        else write_mismatch($sampled(wb.rd), $sampled(wb.data), $sampled(head));

    a_no_marker: assert property (@(posedge clk) disable iff (!rst_n)
        wb.reg_wr |-> wb.rd != 5'd31)
        else begin
            $display("[FAIL] t=%0t shadow slot wrote x31=%0d", $time, $sampled(wb.data));
            flag_error(($sampled(wb.data) < 4) ? 4 : 5); // markers 1..3 follow the beq
        end

    a_halt_drained: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ohalt) |-> head == n_exp)
        else begin
            $display("[FAIL] t=%0t halt with %0d writes outstanding", $time,
                     n_exp - $sampled(head));
            flag_error(6);
        end

    // pop the list on each retirement
    always @(posedge clk) begin
        if (rst_n && wb.reg_wr) head <= head + 1;
    end

    // a test line once the last write of its tag is gone
    always @(negedge clk) begin
        while (reported < head) begin
            if (reported < n_exp &&
                (reported == n_exp - 1 || exp_tag[reported + 1] != exp_tag[reported]))
                report_test(exp_tag[reported]);
            reported++;
        end
    end

    // stimulus, one time unit after the rising edge
    always @(posedge clk) begin
        #1;
        imem_data = instr_u'(fetch_word(imem_addr));
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        imem_data  = instr_u'(NOP_INSTR);
        n_exp      = 0;
        head       = 0;
        reported   = 0;
        fail_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycles     = 0;
        halted     = 1'b0;
        for (int t = 1; t <= 6; t++) test_fail[t] = 0;
        test_name[1] = "reset and first fetch";
        test_name[2] = "alu chain with forwarding";
        test_name[3] = "store, load and load use";
        test_name[4] = "beq not taken and taken";
        test_name[5] = "jal and jalr";
        test_name[6] = "ecall halt";
        void'($urandom(SEED));
        build_program();
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        while (!halted && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (cycles == 6) report_test(1); // quiet window is over by now
            halted = ohalt;
        end
        if (halted) begin
            @(posedge clk);
            @(negedge clk); // halt check runs on this edge
            report_test(6);
        end else begin
            $display("timeout: ohalt did not rise within %0d cycles", TIMEOUT_CYCLES);
            fail_count++;
        end
        $display("summary: %0d tests passed, %0d failed, %0d of %0d writes seen, %0d errors",
                 tests_passed, tests_failed, head, n_exp, fail_count);
        if (fail_count == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/rv_core.sv
// top level of the five-stage rv32 pipeline
// instruction memory lives outside, the core drives imem_addr and
// samples imem_data; retirements show on the wb port
module rv_core import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC   = '0,
    parameter int              DMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic [XLEN-1:0] imem_addr,
    input  instr_u          imem_data,
    output wb_t             wb,
    output logic            ohalt
);

    fd_t                   fd;       // if/id
    de_t                   de;       // id/ex
    em_t                   em;       // ex/mem
    wb_t                   m_fwd;    // result of the instr now in mem
    redirect_t             redirect; // taken branch or jump from ex
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    assign ohalt = wb.halt; // halt marker reached writeback

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .redirect  (redirect),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .fd        (fd)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .fd       (fd),
        .redirect (redirect),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .de       (de)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    execute_stage u_exec (
        .clk      (clk),
        .rst_n    (rst_n),
        .de       (de),
        .m_fwd    (m_fwd),
        .wb       (wb),
        .redirect (redirect),
        .em       (em)
    );

    mem_wb_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_mem_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .em    (em),
        .m_fwd (m_fwd),
        .wb    (wb)
    );

endmodule

//--- verilog/mem_wb_stage.sv
// memory stage with the word data memory, result select and mem/wb
// m_fwd is the selected result before the register, used for forwarding
module mem_wb_stage import rv_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic clk,
    input  logic rst_n,
    input  em_t  em,
    output wb_t  m_fwd,
    output wb_t  wb
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] dmem [DMEM_WORDS];
    logic [AW-1:0]   word_idx;
    logic [XLEN-1:0] load_data;

    assign word_idx  = em.alu_res[AW+1:2]; // byte address to word index
    assign load_data = dmem[word_idx];     // async read, feeds m_fwd directly

    always_ff @(posedge clk) begin
        if (em.ctrl.mem_wr) dmem[word_idx] <= em.store_data;
    end

    // ==================================================================
    // result select
    // ==================================================================
    always_comb begin
        m_fwd.reg_wr = em.ctrl.reg_wr;
        m_fwd.rd     = em.rd;
        m_fwd.halt   = em.ctrl.halt;
        case (em.ctrl.wb_sel)
            WB_MEM:  m_fwd.data = load_data;
            WB_PC4:  m_fwd.data = em.pc4;
            default: m_fwd.data = em.alu_res;
        endcase
    end

    // mem/wb register
    always_ff @(posedge clk) begin
        wb.rd   <= m_fwd.rd;
        wb.data <= m_fwd.data;
        if (!rst_n) begin
            wb.reg_wr <= 1'b0;
            wb.halt   <= 1'b0;
        end else begin
            wb.reg_wr <= m_fwd.reg_wr;
            wb.halt   <= m_fwd.halt;
        end
    end

    // address computed in execute must land inside the memory
    a_dmem_range: assert property (@(posedge clk) disable iff (!rst_n)
        (em.ctrl.mem_wr || em.ctrl.wb_sel == WB_MEM) |->
            em.alu_res[XLEN-1:2] < DMEM_WORDS);

endmodule

//--- verilog/execute_stage.sv
// execute stage, operand forwarding, alu and branch resolution
// forwarding order is mem stage first, then writeback, then id/ex
// a taken branch or jump redirects fetch in the same cycle
module execute_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  de_t       de,
    input  wb_t       m_fwd,
    input  wb_t       wb,
    output redirect_t redirect,
    output em_t       em
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_val; // forwarded rs2, also the store data
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;

    function automatic logic [XLEN-1:0] fwd_operand(
        input logic [REG_ADDR_W-1:0] rs,
        input logic [XLEN-1:0]       reg_val,
        input wb_t                   mem_src,
        input wb_t                   wb_src
    );
        if (mem_src.reg_wr && mem_src.rd == rs) return mem_src.data; // youngest wins
        if (wb_src.reg_wr && wb_src.rd == rs) return wb_src.data;
        return reg_val;
    endfunction

    assign op_a    = fwd_operand(de.rs1, de.rs1_data, m_fwd, wb);
    assign rs2_val = fwd_operand(de.rs2, de.rs2_data, m_fwd, wb);
    assign op_b    = de.ctrl.alu_use_imm ? de.imm : rs2_val;

    // ==================================================================
    // alu
    // ==================================================================
    always_comb begin
        case (de.ctrl.alu_op)
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_SLT:  alu_res = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_res = XLEN'(op_a < op_b);
            default:  alu_res = op_a + op_b;
        endcase
    end

    // beq compares through the sub, jalr targets through the add
    assign redirect.valid  = (de.ctrl.branch && alu_res == '0) || de.ctrl.jump;
    assign redirect.target = de.ctrl.jalr ? alu_res : de.pc + de.imm;

    // ex/mem register
    always_ff @(posedge clk) begin
        em.alu_res    <= alu_res;
        em.store_data <= rs2_val;
        em.rd         <= de.rd;
        em.pc4        <= de.pc + XLEN'(4); // link value for jal/jalr
        if (!rst_n) begin
            em.ctrl <= '0;
        end else begin
            em.ctrl <= de.ctrl;
        end
    end

    a_target_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        redirect.valid |-> redirect.target[1:0] == 2'b00);

endmodule

//--- verilog/reg_file.sv
// 32 x 32 register file, two async read ports and one write port
// a read of the register being written returns the new value
module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data,
    input  wb_t                   wb
);

    logic [XLEN-1:0] regs [1:31]; // x0 has no storage

    function automatic logic [XLEN-1:0] read_port(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       stored,
        input wb_t                   wr
    );
        if (addr == '0) return '0;
        if (wr.reg_wr && wr.rd == addr) return wr.data; // write-through
        return stored;
    endfunction

    assign rs1_data = read_port(rs1_addr, regs[rs1_addr], wb);
    assign rs2_data = read_port(rs2_addr, regs[rs2_addr], wb);

    always_ff @(posedge clk) begin
        if (wb.reg_wr && wb.rd != '0) regs[wb.rd] <= wb.data;
    end

    // decode strips x0 writes, so none should make it to writeback
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb.reg_wr |-> wb.rd != '0);

endmodule

//--- verilog/decode_stage.sv
// decode stage, hardwired decoder plus immediate generation
// reads the register file and fills the id/ex register
// a redirect from execute turns the word in decode into a nop
module decode_stage import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fd_t                   fd,
    input  redirect_t             redirect,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic [XLEN-1:0]       rs1_data,
    input  logic [XLEN-1:0]       rs2_data,
    output de_t                   de
);

    instr_u          instr; // after flush
    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;

    assign instr    = redirect.valid ? instr_u'(NOP_INSTR) : fd.instr;
    assign rs1_addr = instr.r_fmt.rs1;
    assign rs2_addr = instr.r_fmt.rs2;

    // ==================================================================
    // control decode
    // ==================================================================
    always_comb begin
        ctrl = '0; // unknown opcode ends up as nop
        imm  = '0;
        case (instr.r_fmt.opcode)
            OPC_OP: begin
                ctrl.reg_wr = 1'b1;
                case (instr.r_fmt.funct3)
                    3'b000:  ctrl.alu_op = instr.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b011:  ctrl.alu_op = ALU_SLTU;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_wr = 1'b0; // shifts and xor not supported
                endcase
            end
            OPC_OP_IMM: begin
                imm              = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
                ctrl.alu_use_imm = 1'b1;
                ctrl.reg_wr      = (instr.i_fmt.funct3 == 3'b000); // addi only
            end
            OPC_LOAD: begin
                imm              = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
                ctrl.alu_use_imm = 1'b1;
                ctrl.wb_sel      = WB_MEM;
                ctrl.reg_wr      = (instr.i_fmt.funct3 == 3'b010); // lw
            end
            OPC_STORE: begin
                imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                       instr.s_fmt.imm_4_0};
                ctrl.alu_use_imm = 1'b1;
                ctrl.mem_wr      = (instr.s_fmt.funct3 == 3'b010); // sw
            end
            OPC_BRANCH: begin
                imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
                ctrl.alu_op = ALU_SUB;                             // equal means zero
                ctrl.branch = (instr.b_fmt.funct3 == 3'b000);      // beq
            end
            OPC_JAL: begin
                imm = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
                ctrl.jump   = 1'b1;
                ctrl.wb_sel = WB_PC4;
                ctrl.reg_wr = 1'b1;
            end
            OPC_JALR: begin
                imm              = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
                ctrl.alu_use_imm = 1'b1;
                ctrl.jump        = 1'b1;
                ctrl.jalr        = 1'b1; // target is rs1 + imm
                ctrl.wb_sel      = WB_PC4;
                ctrl.reg_wr      = 1'b1;
            end
            OPC_SYSTEM: begin
                // ecall only, ebreak and csr ops fall through as nop
                ctrl.halt = (instr.i_fmt.imm == '0) && (instr.i_fmt.funct3 == 3'b000);
            end
            default: ;
        endcase
        if (instr.r_fmt.rd == '0) begin
            ctrl.reg_wr = 1'b0; // x0 writes are dropped here, not in the rf
        end
    end

    // ==================================================================
    // id/ex register
    // ==================================================================
    always_ff @(posedge clk) begin
        de.rs1      <= rs1_addr;
        de.rs2      <= rs2_addr;
        de.rd       <= instr.r_fmt.rd;
        de.rs1_data <= rs1_data; // already bypassed from wb
        de.rs2_data <= rs2_data;
        de.imm      <= imm;
        de.pc       <= fd.pc;
        if (!rst_n) begin
            de.ctrl <= '0;
        end else begin
            de.ctrl <= ctrl;
        end
    end

    // a writing instr always carries a real result select into execute
    a_wb_sel_legal: assert property (@(posedge clk) disable iff (!rst_n)
        de.ctrl.reg_wr |-> de.ctrl.wb_sel inside {WB_ALU, WB_MEM, WB_PC4});

endmodule

//--- verilog/fetch_stage.sv
// fetch stage, holds the pc and the if/id register
// pc steps by 4 or jumps to the execute redirect target
module fetch_stage import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  redirect_t       redirect,
    output logic [XLEN-1:0] imem_addr,
    input  instr_u          imem_data,
    output fd_t             fd
);

    logic [XLEN-1:0] pc;

    assign imem_addr = pc; // rom answers combinationally

    // pc register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (redirect.valid) begin
            pc <= redirect.target;
        end else begin
            pc <= pc + XLEN'(4);
        end
    end

    // ==================================================================
    // if/id register
    // ==================================================================
    always_ff @(posedge clk) begin
        fd.pc <= pc;
        if (!rst_n) begin
            fd.instr <= instr_u'(NOP_INSTR);
        end else begin
            // the word fetched behind a taken branch is squashed
            fd.instr <= redirect.valid ? instr_u'(NOP_INSTR) : imem_data;
        end
    end

endmodule

//--- verilog/rv_pkg.sv
// shared types for the five-stage rv32 pipeline
// widths, opcode and control encodings, stage payload structs
// and the instruction word union used by fetch and decode
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

    // major opcodes that the core understands, all else decodes as nop
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_SLT  = 3'd4,
        ALU_SLTU = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0, // zero so a cleared ctrl word is a plain alu nop
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

    // ==================================================================
    // instruction formats, msb first
    // ==================================================================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    // ==================================================================
    // control word and stage payloads
    // ==================================================================
    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_use_imm; // operand b from imm instead of rs2
        logic    branch;      // beq, taken on zero sub result
        logic    jump;        // jal or jalr
        logic    jalr;        // target from alu sum
        logic    mem_wr;
        wb_sel_e wb_sel;
        logic    reg_wr;      // never set for rd == x0
        logic    halt;        // ecall marker
    } ctrl_t;

    typedef struct packed {
        instr_u          instr;
        logic [XLEN-1:0] pc;
    } fd_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
    } de_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       alu_res;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pc4;
    } em_t;

    typedef struct packed {
        logic                  reg_wr;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic                  halt;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage
